// File: src.f
+incdir+rtl
rtl/ddcPkg.sv
rtl/ddcRegs.sv
rtl/ddcNco.sv
rtl/complexMixer.sv
rtl/halfbandDecimate.sv
rtl/variableGain.sv
rtl/ddc.sv
tests/ddcTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the DDC testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log
PASS_TEXT="Simulation completed successfully"

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module ddcTb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/VddcTb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "$PASS_TEXT" "$LOG"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1

// File: tests/ddcTb.sv
`timescale 1ns/1ps
`include "ddc_config.svh"

module ddcTb
    import ddcPkg::*;
();

    localparam int IMPULSE = 0;
    localparam int CONSTANT = 1;
    localparam int RANDOM = 2;
    localparam int NUM_CASES = 9;
    localparam longint MAX_SAMPLE = (longint'(1) <<< (`SAMPLE_WIDTH - 1)) - 1;
    localparam longint MIN_SAMPLE = -(longint'(1) <<< (`SAMPLE_WIDTH - 1));

    typedef struct packed {
        freq_t offset;
        freq_t center;
        logic bypass;
        gainExp_t gainExp;
        gainMant_t gainMant;
        int count;
        int pattern;
        int level;
    } stimCase_t;

    logic clk = 1'b0;
    logic reset, syncIn, wr0, wr1, wr2, wr3, syncOut;
    sample_t iIn, qIn, iOut, qOut;
    freq_t freqOffset;
    regAddr_t addr;
    busData_t din, dout;

    stimCase_t cases [NUM_CASES];
    int seed = 35059;
    int cycle = 0;
    int valueErrors = 0;
    int otherErrors = 0;
    longint watchdogCycles = 0;
    longint watchdogNs = 0;
    // Reference model state with the newest sample at history index 0
    freq_t refPhase = '0;
    longint refHistI [7];
    longint refHistQ [7];
    bit refOdd = 1'b0;
    sample_t expI [$];
    sample_t expQ [$];
    int expDue [$];

    ddc ddc_i (.*);

    always #4 clk = ~clk;

    function automatic sample_t clipSample(input longint value);
        if (value > MAX_SAMPLE) begin
            return sample_t'(MAX_SAMPLE);
        end
        if (value < MIN_SAMPLE) begin
            return sample_t'(MIN_SAMPLE);
        end
        return sample_t'(value);
    endfunction

    // Sine is the same table a quarter turn later
    function automatic longint cosPoint(input logic [2:0] k);
        case (k)
            3'd0: return `NCO_FULL;
            3'd1, 3'd7: return `NCO_DIAG;
            3'd2, 3'd6: return 0;
            3'd4: return -`NCO_FULL;
            default: return -`NCO_DIAG;
        endcase
    endfunction

    function automatic longint hbSum(input longint h [7]);
        return 16 * h[3] + 9 * (h[2] + h[4]) - h[0] - h[6];
    endfunction

    function automatic void modelSample(input sample_t sampI, input sample_t sampQ,
        input stimCase_t c, output bit produced, output sample_t outI, output sample_t outQ);
        logic [2:0] k;
        longint co, si, valI, valQ;
        k = refPhase[`FREQ_WIDTH-1 -: 3];
        co = cosPoint(k);
        si = cosPoint(k - 3'd2);
        refPhase = refPhase + (c.offset - c.center);
        valI = clipSample((longint'(sampI) * co - longint'(sampQ) * si) >>> 17);
        valQ = clipSample((longint'(sampI) * si + longint'(sampQ) * co) >>> 17);
        produced = 1'b1;
        if (!c.bypass) begin
            for (int n = 6; n > 0; n--) begin
                refHistI[n] = refHistI[n-1];
                refHistQ[n] = refHistQ[n-1];
            end
            refHistI[0] = valI;
            refHistQ[0] = valQ;
            produced = refOdd;
            refOdd = !refOdd;
            valI = clipSample(hbSum(refHistI) >>> 5);
            valQ = clipSample(hbSum(refHistQ) >>> 5);
        end
        outI = clipSample(((valI * longint'(c.gainMant)) >>> 15) <<< c.gainExp);
        outQ = clipSample(((valQ * longint'(c.gainMant)) >>> 15) <<< c.gainExp);
    endfunction

    task automatic writeReg(input regAddr_t a, input busData_t data, input logic [3:0] lanes);
        @(posedge clk);
        addr <= a;
        din <= data;
        {wr3, wr2, wr1, wr0} <= lanes;
        @(posedge clk);
        {wr3, wr2, wr1, wr0} <= 4'b0000;
    endtask

    task automatic checkRead(input regAddr_t a, input busData_t want);
        @(posedge clk);
        addr <= a;
        @(negedge clk);
        assert (dout === want) else begin
            valueErrors++;
            $display("ERROR: dout at address %0h is %08h, expected %08h", a, dout, want);
        end
    endtask

    task automatic driveSample(input stimCase_t c, input int n);
        sample_t sampI, sampQ, wantI, wantQ;
        bit produced;
        sampI = (c.pattern == IMPULSE && n != 0) ? '0 : sample_t'(c.level);
        sampQ = sampI >>> 1;
        if (c.pattern == RANDOM) begin
            sampI = sample_t'($random(seed));
            sampQ = sample_t'($random(seed));
        end
        @(posedge clk);
        modelSample(sampI, sampQ, c, produced, wantI, wantQ);
        if (produced) begin
            expI.push_back(wantI);
            expQ.push_back(wantQ);
            // Strobe is seen by the DUT one monitor cycle later
            expDue.push_back(cycle + 1 + (c.bypass ? 3 : 4));
        end
        syncIn <= 1'b1;
        iIn <= sampI;
        qIn <= sampQ;
    endtask

    task automatic runCase(input stimCase_t c);
        int waited = 0;
        writeReg(`REG_CENTER_FREQ, c.center, 4'hF);
        writeReg(`REG_CONTROL, busData_t'(c.bypass), 4'hF);
        writeReg(`REG_GAIN, {11'd0, c.gainExp, c.gainMant}, 4'hF);
        @(posedge clk);
        freqOffset <= c.offset;
        for (int n = 0; n < c.count; n++) begin
            driveSample(c, n);
        end
        @(posedge clk);
        syncIn <= 1'b0;
        while (expI.size() != 0 && waited < 12) begin
            @(posedge clk);
            waited++;
        end
        repeat (4) @(posedge clk);
        assert (expI.size() == 0) else begin
            otherErrors++;
            $display("%0d expected output strobes never arrived", expI.size());
            expI.delete();
            expQ.delete();
            expDue.delete();
        end
    endtask

    task automatic checkOutput();
        sample_t wantI, wantQ;
        int due;
        assert (expI.size() != 0) else begin
            otherErrors++;
            $display("Output strobe at cycle %0d with no sample expected", cycle);
        end
        if (expI.size() != 0) begin
            wantI = expI.pop_front();
            wantQ = expQ.pop_front();
            due = expDue.pop_front();
            assert (iOut === wantI) else begin
                valueErrors++;
                $display("ERROR: iOut is %05h, expected %05h", iOut, wantI);
            end
            assert (qOut === wantQ) else begin
                valueErrors++;
                $display("ERROR: qOut is %05h, expected %05h", qOut, wantQ);
            end
            assert (cycle == due) else begin
                otherErrors++;
                $display("Output strobe came at cycle %0d instead of %0d", cycle, due);
            end
        end
    endtask

    always @(negedge clk) begin
        cycle++;
        if (!reset && syncOut === 1'b1) begin
            checkOutput();
        end
    end

    initial begin
        reset = 1'b1;
        {syncIn, wr0, wr1, wr2, wr3} = '0;
        iIn = '0;
        qIn = '0;
        freqOffset = '0;
        addr = '0;
        din = '0;
        for (int n = 0; n < 7; n++) begin
            refHistI[n] = 0;
            refHistQ[n] = 0;
        end
        // offset, center, bypass, exp, mant, count, pattern, level
        cases[0] = '{32'h0, 32'h0, 1'b1, 5'd0, 16'h8000, 16, RANDOM, 0};
        cases[1] = '{32'h3000_0000, 32'h1000_0000, 1'b1, 5'd0, 16'h8000, 24, RANDOM, 0};
        cases[2] = '{32'h2000_0000, 32'h0, 1'b1, 5'd0, 16'h8000, 8, CONSTANT, 131071};
        cases[3] = '{32'h2000_0000, 32'h0, 1'b1, 5'd0, 16'h8000, 8, CONSTANT, -131072};
        cases[4] = '{32'h0, 32'h0, 1'b0, 5'd0, 16'h8000, 16, IMPULSE, 16384};
        cases[5] = '{32'h2000_0000, 32'h0, 1'b0, 5'd1, 16'h8000, 20, RANDOM, 0};
        cases[6] = '{32'h0, 32'h0, 1'b1, 5'd3, 16'hC000, 8, CONSTANT, 1000};
        cases[7] = '{32'h0, 32'h0, 1'b1, 5'd10, 16'h8000, 8, CONSTANT, 20000};
        cases[8] = '{32'h0, 32'h0, 1'b1, 5'd0, 16'h4000, 8, CONSTANT, -3000};
        watchdogCycles = 300;
        foreach (cases[n]) begin
            watchdogCycles += cases[n].count + 40;
        end
        watchdogNs = watchdogCycles * 8;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        // Idle window where the monitor flags any strobe
        repeat (8) @(posedge clk);
        checkRead(`REG_CENTER_FREQ, 32'h0);
        checkRead(`REG_CONTROL, 32'h0);
        checkRead(`REG_GAIN, `GAIN_RESET);
        writeReg(`REG_CENTER_FREQ, 32'hA1B2_C3D4, 4'b0001);
        checkRead(`REG_CENTER_FREQ, 32'h0000_00D4);
        writeReg(`REG_CENTER_FREQ, 32'hA1B2_C3D4, 4'b0100);
        checkRead(`REG_CENTER_FREQ, 32'h00B2_00D4);
        writeReg(`REG_CENTER_FREQ, 32'hA1B2_C3D4, 4'b1010);
        checkRead(`REG_CENTER_FREQ, 32'hA1B2_C3D4);
        writeReg(`REG_GAIN, 32'hFF1F_0000, 4'b0100);
        checkRead(`REG_GAIN, 32'h001F_8000);
        writeReg(4'd7, 32'hFFFF_FFFF, 4'b1111);
        checkRead(4'd7, 32'h0);
        checkRead(`REG_CONTROL, 32'h0);
        for (int n = 0; n < NUM_CASES; n++) begin
            runCase(cases[n]);
        end
        $display("Checks done: %0d value errors, %0d other errors", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        wait (watchdogNs > 0);
        #(watchdogNs);
        $display("Timeout: the run did not finish within %0d ns", watchdogNs);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: rtl/ddc.sv
`timescale 1ns/1ps
`include "ddc_config.svh"

module ddc
    import ddcPkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     syncIn,
    input  sample_t  iIn,
    input  sample_t  qIn,
    input  freq_t    freqOffset,
    input  regAddr_t addr,
    input  busData_t din,
    input  logic     wr0,
    input  logic     wr1,
    input  logic     wr2,
    input  logic     wr3,
    output logic     syncOut,
    output sample_t  iOut,
    output sample_t  qOut,
    output busData_t dout
);

    freq_t centerFreq;
    freq_t ncoStep;
    logic bypassHb;
    gainExp_t gainExp;
    gainMant_t gainMant;
    sample_t ncoCos, ncoSin;
    logic mixSync, hbSync, hbSyncIn, gainSync;
    sample_t iMix, qMix, iHb, qHb, iGain, qGain;

    ddcRegs regs_i (
        .clk(clk), .reset(reset),
        .addr(addr), .din(din),
        .wr0(wr0), .wr1(wr1), .wr2(wr2), .wr3(wr3),
        .dout(dout),
        .centerFreq(centerFreq), .bypassHb(bypassHb),
        .gainExp(gainExp), .gainMant(gainMant)
    );

    // LO runs at the offset relative to the programmed center
    assign ncoStep = freqOffset - centerFreq;

    ddcNco nco_i (
        .clk(clk), .reset(reset),
        .step(ncoStep), .advance(syncIn),
        .cosOut(ncoCos), .sinOut(ncoSin)
    );

    complexMixer mixer_i (
        .clk(clk), .reset(reset),
        .syncIn(syncIn), .iIn(iIn), .qIn(qIn),
        .cosIn(ncoCos), .sinIn(ncoSin),
        .syncOut(mixSync), .iOut(iMix), .qOut(qMix)
    );

    // Halfband sits idle while bypassed
    assign hbSyncIn = mixSync & ~bypassHb;

    halfbandDecimate hb_i (
        .clk(clk), .reset(reset),
        .syncIn(hbSyncIn), .iIn(iMix), .qIn(qMix),
        .syncOut(hbSync), .iOut(iHb), .qOut(qHb)
    );

    assign gainSync = bypassHb ? mixSync : hbSync;
    assign iGain = bypassHb ? iMix : iHb;
    assign qGain = bypassHb ? qMix : qHb;

    variableGain gain_i (
        .clk(clk), .reset(reset),
        .syncIn(gainSync), .iIn(iGain), .qIn(qGain),
        .gainExp(gainExp), .gainMant(gainMant),
        .syncOut(syncOut), .iOut(iOut), .qOut(qOut)
    );

endmodule

// File: rtl/variableGain.sv
`timescale 1ns/1ps
`include "ddc_config.svh"

module variableGain
    import ddcPkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      syncIn,
    input  sample_t   iIn,
    input  sample_t   qIn,
    input  gainExp_t  gainExp,
    input  gainMant_t gainMant,
    output logic      syncOut,
    output sample_t   iOut,
    output sample_t   qOut
);

    // Mantissa is Q1.15, so drop 15 bits before the exponent shift
    function automatic sample_t scaleRail(
        input sample_t sample,
        input gainMant_t mant,
        input gainExp_t shift
    );
        logic signed [`SAMPLE_WIDTH+16:0] product;
        logic signed [63:0] wide;
        product = sample * $signed({1'b0, mant});
        wide = product >>> 15;
        return saturate(wide <<< shift);
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            syncOut <= 1'b0;
            iOut <= '0;
            qOut <= '0;
        end else begin
            syncOut <= syncIn;
            if (syncIn) begin
                iOut <= scaleRail(iIn, gainMant, gainExp);
                qOut <= scaleRail(qIn, gainMant, gainExp);
            end
        end
    end

endmodule

// File: rtl/halfbandDecimate.sv
`timescale 1ns/1ps
`include "ddc_config.svh"

module halfbandDecimate
    import ddcPkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    syncIn,
    input  sample_t iIn,
    input  sample_t qIn,
    output logic    syncOut,
    output sample_t iOut,
    output sample_t qOut
);

    localparam int ACC_WIDTH = `SAMPLE_WIDTH + 10;

    // Older samples, index 0 is the most recent
    sample_t histI [6];
    sample_t histQ [6];
    // Seven-sample window including the incoming sample
    sample_t winI [7];
    sample_t winQ [7];
    logic oddSample;
    logic signed [ACC_WIDTH-1:0] accI, accQ;

    always_comb begin
        winI[0] = iIn;
        winQ[0] = qIn;
        for (int n = 1; n < 7; n++) begin
            winI[n] = histI[n-1];
            winQ[n] = histQ[n-1];
        end
    end

    // Taps -1, 0, 9, 16, 9, 0, -1
    function automatic logic signed [ACC_WIDTH-1:0] tapSum(
        input sample_t w0,
        input sample_t w2,
        input sample_t w3,
        input sample_t w4,
        input sample_t w6
    );
        logic signed [ACC_WIDTH-1:0] outer;
        logic signed [ACC_WIDTH-1:0] inner;
        logic signed [ACC_WIDTH-1:0] center;
        outer = ACC_WIDTH'(w0) + ACC_WIDTH'(w6);
        inner = ACC_WIDTH'(w2) + ACC_WIDTH'(w4);
        center = ACC_WIDTH'(w3) <<< 4;
        return center + (inner <<< 3) + inner - outer;
    endfunction

    assign accI = tapSum(winI[0], winI[2], winI[3], winI[4], winI[6]);
    assign accQ = tapSum(winQ[0], winQ[2], winQ[3], winQ[4], winQ[6]);

    always_ff @(posedge clk) begin
        if (reset) begin
            oddSample <= 1'b0;
            for (int n = 0; n < 6; n++) begin
                histI[n] <= '0;
                histQ[n] <= '0;
            end
        end else if (syncIn) begin
            oddSample <= ~oddSample;
            for (int n = 0; n < 6; n++) begin
                histI[n] <= winI[n];
                histQ[n] <= winQ[n];
            end
        end
    end

    // Keep only every second sample
    always_ff @(posedge clk) begin
        if (reset) begin
            syncOut <= 1'b0;
            iOut <= '0;
            qOut <= '0;
        end else begin
            syncOut <= syncIn & oddSample;
            if (syncIn && oddSample) begin
                iOut <= saturate(accI >>> 5);
                qOut <= saturate(accQ >>> 5);
            end
        end
    end

endmodule

// File: rtl/complexMixer.sv
`timescale 1ns/1ps
`include "ddc_config.svh"

module complexMixer
    import ddcPkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    syncIn,
    input  sample_t iIn,
    input  sample_t qIn,
    input  sample_t cosIn,
    input  sample_t sinIn,
    output logic    syncOut,
    output sample_t iOut,
    output sample_t qOut
);

    logic signed [2*`SAMPLE_WIDTH-1:0] prodIc, prodQs, prodIs, prodQc;
    logic signed [2*`SAMPLE_WIDTH:0] sumReal, sumImag;
    logic syncProd;

    // First stage holds the four partial products
    always_ff @(posedge clk) begin
        if (reset) begin
            prodIc <= '0;
            prodQs <= '0;
            prodIs <= '0;
            prodQc <= '0;
        end else begin
            prodIc <= iIn * cosIn;
            prodQs <= qIn * sinIn;
            prodIs <= iIn * sinIn;
            prodQc <= qIn * cosIn;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            syncProd <= 1'b0;
        end else begin
            syncProd <= syncIn;
        end
    end

    assign sumReal = prodIc - prodQs;
    assign sumImag = prodIs + prodQc;

    // Second stage drops 17 fraction bits and clips
    always_ff @(posedge clk) begin
        if (reset) begin
            syncOut <= 1'b0;
            iOut <= '0;
            qOut <= '0;
        end else begin
            syncOut <= syncProd;
            if (syncProd) begin
                iOut <= saturate(sumReal >>> 17);
                qOut <= saturate(sumImag >>> 17);
            end
        end
    end

endmodule

// File: rtl/ddcNco.sv
`timescale 1ns/1ps
`include "ddc_config.svh"

module ddcNco
    import ddcPkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  freq_t   step,
    input  logic    advance,
    output sample_t cosOut,
    output sample_t sinOut
);

    localparam sample_t FULL = `NCO_FULL;
    localparam sample_t DIAG = `NCO_DIAG;

    freq_t phase;
    logic [2:0] tableIndex;

    // Current phase is used first, then stepped
    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= '0;
        end else if (advance) begin
            phase <= phase + step;
        end
    end

    assign tableIndex = phase[`FREQ_WIDTH-1 -: 3];

    // Eight points around the circle, 45 degrees apart
    always_comb begin
        case (tableIndex)
            3'd0: begin cosOut = FULL;  sinOut = '0;    end
            3'd1: begin cosOut = DIAG;  sinOut = DIAG;  end
            3'd2: begin cosOut = '0;    sinOut = FULL;  end
            3'd3: begin cosOut = -DIAG; sinOut = DIAG;  end
            3'd4: begin cosOut = -FULL; sinOut = '0;    end
            3'd5: begin cosOut = -DIAG; sinOut = -DIAG; end
            3'd6: begin cosOut = '0;    sinOut = -FULL; end
            default: begin
                cosOut = DIAG;
                sinOut = -DIAG;
            end
        endcase
    end

endmodule

// File: rtl/ddcRegs.sv
`timescale 1ns/1ps
`include "ddc_config.svh"

module ddcRegs
    import ddcPkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  regAddr_t  addr,
    input  busData_t  din,
    input  logic      wr0,
    input  logic      wr1,
    input  logic      wr2,
    input  logic      wr3,
    output busData_t  dout,
    output freq_t     centerFreq,
    output logic      bypassHb,
    output gainExp_t  gainExp,
    output gainMant_t gainMant
);

    busData_t centerFreqReg;
    busData_t controlReg;
    busData_t gainReg;
    logic [3:0] wrLane;

    assign wrLane = {wr3, wr2, wr1, wr0};

    // Each strobe loads one byte lane of the addressed word
    always_ff @(posedge clk) begin
        if (reset) begin
            centerFreqReg <= '0;
            controlReg <= '0;
            gainReg <= `GAIN_RESET;
        end else begin
            for (int lane = 0; lane < 4; lane++) begin
                if (wrLane[lane]) begin
                    case (addr)
                        `REG_CENTER_FREQ: centerFreqReg[lane*8 +: 8] <= din[lane*8 +: 8];
                        `REG_CONTROL:     controlReg[lane*8 +: 8] <= din[lane*8 +: 8];
                        `REG_GAIN:        gainReg[lane*8 +: 8] <= din[lane*8 +: 8];
                        default:          ;
                    endcase
                end
            end
        end
    end

    always_comb begin
        case (addr)
            `REG_CENTER_FREQ: dout = centerFreqReg;
            `REG_CONTROL:     dout = controlReg;
            `REG_GAIN:        dout = gainReg;
            default:          dout = '0;
        endcase
    end

    assign centerFreq = freq_t'(centerFreqReg);
    assign bypassHb = controlReg[0];
    assign gainExp = gainReg[20:16];
    assign gainMant = gainReg[15:0];

endmodule

// File: rtl/ddcPkg.sv
`include "ddc_config.svh"

package ddcPkg;

    typedef logic signed [`SAMPLE_WIDTH-1:0] sample_t;
    typedef logic [`FREQ_WIDTH-1:0] freq_t;
    typedef logic [`REG_ADDR_WIDTH-1:0] regAddr_t;
    typedef logic [4:0] gainExp_t;
    // Unsigned, 0x8000 is unity
    typedef logic [15:0] gainMant_t;
    typedef logic [31:0] busData_t;

    localparam logic signed [63:0] SAT_MAX = (64'sd1 <<< (`SAMPLE_WIDTH - 1)) - 64'sd1;
    localparam logic signed [63:0] SAT_MIN = -(64'sd1 <<< (`SAMPLE_WIDTH - 1));

    // Clip a wide signed value into one sample
    function automatic sample_t saturate(input logic signed [63:0] value);
        if (value > SAT_MAX) begin
            return sample_t'(SAT_MAX);
        end
        if (value < SAT_MIN) begin
            return sample_t'(SAT_MIN);
        end
        return sample_t'(value);
    endfunction

endpackage

// File: rtl/ddc_config.svh
`ifndef DDC_CONFIG_SVH
`define DDC_CONFIG_SVH

// Datapath widths
`define SAMPLE_WIDTH    18
`define FREQ_WIDTH      32
`define REG_ADDR_WIDTH  4

// Register word addresses
`define REG_CENTER_FREQ 4'd0
`define REG_CONTROL     4'd1
`define REG_GAIN        4'd2

// NCO table magnitudes, full scale and full scale times sqrt(0.5)
`define NCO_FULL        131071
`define NCO_DIAG        92682

// Exponent 0, mantissa 1.0
`define GAIN_RESET      32'h0000_8000

`endif
